// File: design/holy_core_pkg.sv
package holy_core_pkg;

    // Widths that carry a meaning across the core
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // RV32I major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_control_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_source_t;

    typedef enum logic {ALU_SOURCE_RD, ALU_SOURCE_IMM} alu_source_t;

    typedef enum logic [1:0] {
        WB_SOURCE_ALU_RESULT,
        WB_SOURCE_MEM_READ,
        WB_SOURCE_PC_PLUS_FOUR,
        WB_SOURCE_SECOND_ADD
    } wb_source_t;

    typedef enum logic {SOURCE_PC_PLUS_4, SOURCE_PC_SECOND_ADD} pc_source_t;

    // ZERO passes the immediate through for LUI
    typedef enum logic [1:0] {
        SECOND_ADDER_SOURCE_PC,
        SECOND_ADDER_SOURCE_ZERO,
        SECOND_ADDER_SOURCE_RD
    } second_add_source_t;

    typedef struct packed {
        alu_control_t       alu_control;
        imm_source_t        imm_source;
        alu_source_t        alu_source;
        wb_source_t         wb_source;
        pc_source_t         pc_source;
        second_add_source_t second_add_source;
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
    } ctrl_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
        logic       write;
        logic       read;
    } dmem_req_t;

    // Load and store widths
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_HALF   = 3'b001;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;
    localparam logic [2:0] F3_HALF_U = 3'b101;

endpackage

// File: design/pc_unit.sv
module pc_unit import holy_core_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  ctrl_t i_ctrl,
    input  word_t i_imm,
    input  word_t i_rs1,
    output word_t o_pc,
    output word_t o_pc_plus_four,
    output word_t o_second_add
);

    word_t pc_next;

    assign o_pc_plus_four = o_pc + 32'd4;

    // Targets for branches, JAL, JALR, AUIPC and LUI
    always_comb begin
        case (i_ctrl.second_add_source)
            SECOND_ADDER_SOURCE_PC:   o_second_add = o_pc + i_imm;
            SECOND_ADDER_SOURCE_ZERO: o_second_add = i_imm;
            SECOND_ADDER_SOURCE_RD:   o_second_add = i_rs1 + i_imm;
            default:                  o_second_add = '0;
        endcase
    end

    // Bit 0 cleared for JALR, other targets already even
    assign pc_next = (i_ctrl.pc_source == SOURCE_PC_SECOND_ADD) ?
                     {o_second_add[31:1], 1'b0} : o_pc_plus_four;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pc <= RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) o_pc[1:0] == 2'b00);

endmodule

// File: design/control.sv
module control import holy_core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t i_instr,
    input  logic  i_alu_zero,
    input  logic  i_alu_last_bit,
    output ctrl_t o_ctrl
);

    opcode_t      opcode;
    logic [2:0]   funct3;
    logic         alt_op;
    alu_control_t arith_op;
    logic         branch_taken;
    ctrl_t        ctrl;

    assign opcode = opcode_t'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    // funct7 bit 5 selects SUB and SRA
    assign alt_op = i_instr[30];

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && alt_op) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt_op ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    // BEQ/BNE look at zero after SUB, the others at the SLT/SLTU bit
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = i_alu_zero;
            3'b001:  branch_taken = !i_alu_zero;
            3'b100:  branch_taken = i_alu_last_bit;
            3'b101:  branch_taken = !i_alu_last_bit;
            3'b110:  branch_taken = i_alu_last_bit;
            3'b111:  branch_taken = !i_alu_last_bit;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            OPC_OP: begin
                ctrl.alu_control = arith_op;
                ctrl.reg_write   = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_control = arith_op;
                ctrl.alu_source  = ALU_SOURCE_IMM;
                ctrl.reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.alu_source = ALU_SOURCE_IMM;
                ctrl.wb_source  = WB_SOURCE_MEM_READ;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            OPC_STORE: begin
                ctrl.imm_source = IMM_S;
                ctrl.alu_source = ALU_SOURCE_IMM;
                // Only SB, SH and SW reach memory
                ctrl.mem_write  = (funct3 == F3_BYTE || funct3 == F3_HALF || funct3 == F3_WORD);
            end
            OPC_BRANCH: begin
                ctrl.imm_source  = IMM_B;
                ctrl.alu_control = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
                ctrl.pc_source   = branch_taken ? SOURCE_PC_SECOND_ADD : SOURCE_PC_PLUS_4;
            end
            OPC_JAL: begin
                ctrl.imm_source = IMM_J;
                ctrl.wb_source  = WB_SOURCE_PC_PLUS_FOUR;
                ctrl.pc_source  = SOURCE_PC_SECOND_ADD;
                ctrl.reg_write  = 1'b1;
            end
            OPC_JALR: begin
                ctrl.second_add_source = SECOND_ADDER_SOURCE_RD;
                ctrl.wb_source         = WB_SOURCE_PC_PLUS_FOUR;
                ctrl.pc_source         = SOURCE_PC_SECOND_ADD;
                ctrl.reg_write         = 1'b1;
            end
            OPC_LUI: begin
                ctrl.imm_source        = IMM_U;
                ctrl.second_add_source = SECOND_ADDER_SOURCE_ZERO;
                ctrl.wb_source         = WB_SOURCE_SECOND_ADD;
                ctrl.reg_write         = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.imm_source = IMM_U;
                ctrl.wb_source  = WB_SOURCE_SECOND_ADD;
                ctrl.reg_write  = 1'b1;
            end
            default: ;
        endcase
    end

    // No state may change while the core is held in reset
    always_comb begin
        o_ctrl = ctrl;
        if (!rst_n) begin
            o_ctrl.reg_write = 1'b0;
            o_ctrl.mem_read  = 1'b0;
            o_ctrl.mem_write = 1'b0;
        end
    end

    a_no_read_write: assert property (@(posedge clk) !(o_ctrl.mem_read && o_ctrl.mem_write));

endmodule

// File: design/regfile.sv
module regfile import holy_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    input  reg_addr_t i_rd_addr,
    input  logic      i_write_enable,
    input  word_t     i_write_data,
    output word_t     o_rs1,
    output word_t     o_rs2
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write_enable && i_rd_addr != 5'd0) begin
            regs[i_rd_addr] <= i_write_data;
        end
    end

    assign o_rs1 = regs[i_rs1_addr];
    assign o_rs2 = regs[i_rs2_addr];

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (i_rs1_addr == 5'd0) |-> (o_rs1 == '0));

endmodule

// File: design/signext.sv
module signext import holy_core_pkg::*; (
    input  logic [24:0] i_raw,
    input  imm_source_t i_imm_source,
    output word_t       o_imm
);

    logic sign;

    // i_raw[k] is instruction bit k+7
    assign sign = i_raw[24];

    always_comb begin
        case (i_imm_source)
            IMM_I: o_imm = {{20{sign}}, i_raw[24:13]};
            IMM_S: o_imm = {{20{sign}}, i_raw[24:18], i_raw[4:0]};
            IMM_B: o_imm = {{20{sign}}, i_raw[0], i_raw[23:18], i_raw[4:1], 1'b0};
            IMM_U: o_imm = {i_raw[24:5], 12'b0};
            IMM_J: o_imm = {{12{sign}}, i_raw[12:5], i_raw[13], i_raw[23:14], 1'b0};
            default: o_imm = '0;
        endcase
    end

endmodule

// File: design/alu.sv
module alu import holy_core_pkg::*; (
    input  ctrl_t i_ctrl,
    input  word_t i_rs1,
    input  word_t i_rs2,
    input  word_t i_imm,
    output word_t o_result,
    output logic  o_zero,
    output logic  o_last_bit
);

    word_t      src2;
    logic [4:0] shamt;

    assign src2  = (i_ctrl.alu_source == ALU_SOURCE_IMM) ? i_imm : i_rs2;
    assign shamt = src2[4:0];

    always_comb begin
        case (i_ctrl.alu_control)
            ALU_ADD:  o_result = i_rs1 + src2;
            ALU_SUB:  o_result = i_rs1 - src2;
            ALU_AND:  o_result = i_rs1 & src2;
            ALU_OR:   o_result = i_rs1 | src2;
            ALU_XOR:  o_result = i_rs1 ^ src2;
            ALU_SLL:  o_result = i_rs1 << shamt;
            ALU_SRL:  o_result = i_rs1 >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_rs1) >>> shamt);
            ALU_SLT:  o_result = {31'b0, $signed(i_rs1) < $signed(src2)};
            ALU_SLTU: o_result = {31'b0, i_rs1 < src2};
            default:  o_result = '0;
        endcase
    end

    // Flags read by the branch decision in control
    assign o_zero     = (o_result == '0);
    assign o_last_bit = o_result[0];

endmodule

// File: design/load_store_decoder.sv
module load_store_decoder import holy_core_pkg::*; (
    input  ctrl_t      i_ctrl,
    input  word_t      i_addr,
    input  word_t      i_rs2,
    input  logic [2:0] i_funct3,
    output dmem_req_t  o_dmem_req
);

    logic [1:0] offset;

    assign offset = i_addr[1:0];

    always_comb begin
        o_dmem_req.addr  = {i_addr[31:2], 2'b00};
        o_dmem_req.write = i_ctrl.mem_write;
        o_dmem_req.read  = i_ctrl.mem_read;
        case (i_funct3)
            F3_BYTE, F3_BYTE_U: begin
                o_dmem_req.byte_en = 4'b0001 << offset;
                o_dmem_req.wdata   = i_rs2 << {offset, 3'b000};
            end
            F3_HALF, F3_HALF_U: begin
                o_dmem_req.byte_en = offset[1] ? 4'b1100 : 4'b0011;
                o_dmem_req.wdata   = i_rs2 << {offset, 3'b000};
            end
            F3_WORD: begin
                o_dmem_req.byte_en = 4'b1111;
                o_dmem_req.wdata   = i_rs2;
            end
            default: begin
                o_dmem_req.byte_en = 4'b0000;
                o_dmem_req.wdata   = '0;
            end
        endcase
        a_write_has_lanes: assert final (!o_dmem_req.write || o_dmem_req.byte_en != 4'b0000);
    end

endmodule

// File: design/load_write_back.sv
module load_write_back import holy_core_pkg::*; (
    input  ctrl_t      i_ctrl,
    input  word_t      i_rdata,
    input  logic [3:0] i_byte_en,
    input  logic [2:0] i_funct3,
    input  word_t      i_alu_result,
    input  word_t      i_pc_plus_four,
    input  word_t      i_second_add,
    output word_t      o_wb_data,
    output logic       o_wb_valid
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    word_t       load_data;
    logic        load_valid;

    // Pick the lane the decoder enabled
    always_comb begin
        case (i_byte_en)
            4'b0010: lane_byte = i_rdata[15:8];
            4'b0100: lane_byte = i_rdata[23:16];
            4'b1000: lane_byte = i_rdata[31:24];
            default: lane_byte = i_rdata[7:0];
        endcase
        lane_half = (i_byte_en == 4'b1100) ? i_rdata[31:16] : i_rdata[15:0];
    end

    always_comb begin
        load_valid = 1'b1;
        case (i_funct3)
            F3_BYTE:   load_data = {{24{lane_byte[7]}}, lane_byte};
            F3_BYTE_U: load_data = {24'b0, lane_byte};
            F3_HALF:   load_data = {{16{lane_half[15]}}, lane_half};
            F3_HALF_U: load_data = {16'b0, lane_half};
            F3_WORD:   load_data = i_rdata;
            default: begin
                load_data  = '0;
                load_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        o_wb_valid = 1'b1;
        case (i_ctrl.wb_source)
            WB_SOURCE_MEM_READ: begin
                o_wb_data  = load_data;
                o_wb_valid = load_valid;
            end
            WB_SOURCE_PC_PLUS_FOUR: o_wb_data = i_pc_plus_four;
            WB_SOURCE_SECOND_ADD:   o_wb_data = i_second_add;
            default:                o_wb_data = i_alu_result;
        endcase
    end

endmodule

// File: design/holy_core.sv
module holy_core import holy_core_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     i_instr,
    output word_t     o_pc,
    output dmem_req_t o_dmem_req,
    input  word_t     i_dmem_rdata
);

    ctrl_t ctrl;
    word_t pc_plus_four;
    word_t second_add;
    word_t imm;
    word_t rs1;
    word_t rs2;
    word_t alu_result;
    logic  alu_zero;
    logic  alu_last_bit;
    word_t wb_data;
    logic  wb_valid;

    control control_unit (
        .clk(clk), .rst_n(rst_n), .i_instr(i_instr),
        .i_alu_zero(alu_zero), .i_alu_last_bit(alu_last_bit), .o_ctrl(ctrl)
    );

    pc_unit #(.RESET_PC(RESET_PC)) pc_inst (
        .clk(clk), .rst_n(rst_n), .i_ctrl(ctrl), .i_imm(imm), .i_rs1(rs1),
        .o_pc(o_pc), .o_pc_plus_four(pc_plus_four), .o_second_add(second_add)
    );

    // A load with a bad width must not touch the destination
    regfile regfile_inst (
        .clk(clk), .rst_n(rst_n),
        .i_rs1_addr(i_instr[19:15]), .i_rs2_addr(i_instr[24:20]), .i_rd_addr(i_instr[11:7]),
        .i_write_enable(ctrl.reg_write && wb_valid), .i_write_data(wb_data),
        .o_rs1(rs1), .o_rs2(rs2)
    );

    signext sign_extender (.i_raw(i_instr[31:7]), .i_imm_source(ctrl.imm_source), .o_imm(imm));

    alu alu_inst (
        .i_ctrl(ctrl), .i_rs1(rs1), .i_rs2(rs2), .i_imm(imm),
        .o_result(alu_result), .o_zero(alu_zero), .o_last_bit(alu_last_bit)
    );

    load_store_decoder ls_decode (
        .i_ctrl(ctrl), .i_addr(alu_result), .i_rs2(rs2), .i_funct3(i_instr[14:12]),
        .o_dmem_req(o_dmem_req)
    );

    load_write_back wb_inst (
        .i_ctrl(ctrl), .i_rdata(i_dmem_rdata), .i_byte_en(o_dmem_req.byte_en),
        .i_funct3(i_instr[14:12]), .i_alu_result(alu_result),
        .i_pc_plus_four(pc_plus_four), .i_second_add(second_add),
        .o_wb_data(wb_data), .o_wb_valid(wb_valid)
    );

endmodule

// File: verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Expected outcome of one instruction
typedef struct packed {
    word_t      next_pc;
    logic       is_store;
    logic       is_load;
    word_t      addr;
    word_t      data;
    logic [3:0] be;
} step_t;

word_t ref_regs [32];
word_t ref_pc;
word_t ref_mem [word_t];

function automatic word_t ref_read(input word_t addr);
    word_t a;
    a = {addr[31:2], 2'b00};
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
endfunction

// Integer operation by funct3, alt selects SUB or SRA
function automatic word_t ref_alu(input logic [2:0] f3, input logic alt, input word_t x,
                                  input word_t y);
    case (f3)
        3'd0:    return alt ? x - y : x + y;
        3'd1:    return x << y[4:0];
        3'd2:    return {31'b0, $signed(x) < $signed(y)};
        3'd3:    return {31'b0, x < y};
        3'd4:    return x ^ y;
        3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6:    return x | y;
        default: return x & y;
    endcase
endfunction

function automatic step_t ref_step(input word_t instr);
    step_t      s;
    word_t      a, b, val, w, addr;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    logic       wr, taken;
    logic [2:0] f3;
    a     = ref_regs[instr[19:15]];
    b     = ref_regs[instr[24:20]];
    f3    = instr[14:12];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {instr[31:12], 12'b0};
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    s = '0;
    s.next_pc = ref_pc + 32'd4;
    wr = 1'b1;
    val = '0;
    case (instr[6:0])
        OPC_OP:     val = ref_alu(f3, instr[30], a, b);
        OPC_OP_IMM: val = ref_alu(f3, f3 == 3'd5 && instr[30], a, imm_i);
        OPC_LUI:    val = imm_u;
        OPC_AUIPC:  val = ref_pc + imm_u;
        OPC_JAL: begin
            val = ref_pc + 32'd4;
            s.next_pc = ref_pc + imm_j;
        end
        OPC_JALR: begin
            val = ref_pc + 32'd4;
            s.next_pc = (a + imm_i) & ~32'd1;
        end
        OPC_BRANCH: begin
            wr = 1'b0;
            case (f3)
                3'd0:    taken = (a == b);
                3'd1:    taken = (a != b);
                3'd4:    taken = $signed(a) < $signed(b);
                3'd5:    taken = $signed(a) >= $signed(b);
                3'd6:    taken = a < b;
                3'd7:    taken = a >= b;
                default: taken = 1'b0;
            endcase
            if (taken) s.next_pc = ref_pc + imm_b;
        end
        OPC_LOAD: begin
            addr = a + imm_i;
            s.is_load = 1'b1;
            s.addr = {addr[31:2], 2'b00};
            w = ref_read(addr) >> {addr[1:0], 3'b000};
            case (f3)
                3'd0:    val = {{24{w[7]}}, w[7:0]};
                3'd4:    val = {24'b0, w[7:0]};
                3'd1:    val = {{16{w[15]}}, w[15:0]};
                3'd5:    val = {16'b0, w[15:0]};
                3'd2:    val = w;
                default: wr = 1'b0;
            endcase
        end
        OPC_STORE: begin
            wr = 1'b0;
            addr = a + imm_s;
            s.is_store = (f3 <= 3'd2);
            s.addr = {addr[31:2], 2'b00};
            s.data = b << {addr[1:0], 3'b000};
            s.be = (f3 == 3'd2) ? 4'b1111 : (f3 == 3'd1 ? 4'b0011 : 4'b0001) << addr[1:0];
            if (s.is_store) ref_mem[s.addr] = merge_lanes(ref_read(s.addr), s.data, s.be);
        end
        default: wr = 1'b0;
    endcase
    if (wr && instr[11:7] != 5'd0) ref_regs[instr[11:7]] = val;
    ref_pc = s.next_pc;
    return s;
endfunction

`endif

// File: verification/holy_core_tb.sv
module holy_core_tb import holy_core_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_PC     = 32'h0000_1000;
    localparam int    RANDOM_COUNT = 2000;
    // Reset, directed code and random stream, one cycle each, plus margin
    localparam int    WATCHDOG_NS  = (10 + 200 + RANDOM_COUNT) * 10 + 500;

    logic      clk;
    logic      rst_n;
    word_t     i_instr;
    word_t     i_dmem_rdata;
    word_t     o_pc;
    dmem_req_t o_dmem_req;

    word_t imem [word_t];
    word_t dmem [word_t];
    word_t lcg_state;
    word_t load_pc;
    word_t sec_start [5];
    word_t rand_start;
    logic  in_random;
    logic  started;
    int    phase;
    int    random_done;
    int    test_errs [6];
    string test_names [6] = '{"reset", "alu", "branch", "store", "load", "random"};
    logic [2:0] branch_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [2:0] load_f3 [5] = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2};

    holy_core #(.RESET_PC(RESET_PC)) uut (
        .clk(clk), .rst_n(rst_n), .i_instr(i_instr), .o_pc(o_pc),
        .o_dmem_req(o_dmem_req), .i_dmem_rdata(i_dmem_rdata)
    );

    `include "rv_ref_model.svh"

    function automatic word_t fill_word(input word_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
    endfunction

    function automatic word_t lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t data, input logic [3:0] be);
        return (old & ~lane_mask(be)) | (data & lane_mask(be));
    endfunction

    function automatic word_t read_dmem(input word_t a);
        return dmem.exists(a) ? dmem[a] : fill_word(a);
    endfunction

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Low LCG bits repeat quickly, so only the upper halves are used
    function automatic word_t rand_word();
        word_t a, b;
        a = lcg_next();
        b = lcg_next();
        return {a[31:16], b[31:16]};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // Aligned data address in 0x400..0x7ff, x0 is the base
    function automatic logic [11:0] data_addr(input logic [2:0] f3, input word_t s);
        logic [11:0] a;
        a = 12'h400 | {2'b00, s[17:10], 2'b00};
        if (f3[1:0] == 2'b00) a[1:0] = s[9:8];
        if (f3[1:0] == 2'b01) a[1] = s[8];
        return a;
    endfunction

    function automatic word_t gen_instr();
        word_t      r, s;
        logic [2:0] f3;
        logic [11:0] imm;
        r = rand_word();
        s = rand_word();
        f3 = r[14:12];
        case (s[31:28])
            4'd4, 4'd5, 4'd6: begin
                if (f3 == 3'd1) imm = {7'b0, s[4:0]};
                else if (f3 == 3'd5) imm = {1'b0, s[5], 5'b0, s[4:0]};
                else imm = s[11:0];
                return enc_i(imm, r[19:15], f3, r[11:7], OPC_OP_IMM);
            end
            4'd7: return enc_u(s[19:0], r[11:7], OPC_LUI);
            4'd8: return enc_u(s[19:0], r[11:7], OPC_AUIPC);
            4'd9: begin
                f3 = load_f3[s[2:0] % 3'd5];
                return enc_i(data_addr(f3, s), 5'd0, f3, r[11:7], OPC_LOAD);
            end
            4'd10: begin
                f3 = {1'b0, s[1:0] % 2'd3};
                return enc_s(data_addr(f3, s), r[24:20], 5'd0, f3);
            end
            // Forward targets only, so the stream keeps moving into fresh code
            4'd11, 4'd12: return enc_b({6'b0, s[4:0], 2'b00} + 13'd4, r[24:20], r[19:15],
                                       branch_f3[s[7:5] % 3'd6]);
            4'd13: return enc_j({13'b0, s[5:0], 2'b00} + 21'd4, r[11:7]);
            4'd14: return enc_i(12'h100 + {2'b00, s[7:0], 2'b00}, 5'd0, 3'd0, r[11:7], OPC_JALR);
            default: return enc_r((f3 == 3'd0 || f3 == 3'd5) && s[0] ? 7'h20 : 7'h00,
                                  r[24:20], r[19:15], f3, r[11:7]);
        endcase
    endfunction

    function automatic word_t fetch_instr(input word_t pc);
        if (!imem.exists(pc)) imem[pc] = gen_instr();
        return imem[pc];
    endfunction

    task automatic emit(input word_t w);
        imem[load_pc] = w;
        load_pc = load_pc + 32'd4;
    endtask

    task automatic load_directed();
        logic [2:0]  f3;
        logic [11:0] off;
        load_pc = RESET_PC;
        sec_start[1] = load_pc;
        emit(enc_u(20'h12345, 5'd1, OPC_LUI));
        emit(enc_i(12'h678, 5'd1, 3'd0, 5'd1, OPC_OP_IMM));
        emit(enc_i(12'hFFB, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
        for (int k = 0; k < 8; k++) begin
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'(k), 5'(3 + k)));
            emit(enc_i(k == 5 ? 12'h407 : (k == 1 ? 12'h007 : 12'h8A5), 5'd1, 3'(k),
                       5'(11 + k), OPC_OP_IMM));
        end
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd19));
        emit(enc_r(7'h20, 5'd1, 5'd2, 3'd5, 5'd20));
        emit(enc_i(12'h005, 5'd0, 3'd0, 5'd0, OPC_OP_IMM));
        emit(enc_u(20'h00001, 5'd21, OPC_AUIPC));
        for (int k = 0; k < 22; k++) emit(enc_s(12'h400 + 12'(4 * k), 5'(k), 5'd0, F3_WORD));
        sec_start[2] = load_pc;
        emit(enc_i(12'h003, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        emit(enc_i(12'hFFD, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
        emit(enc_i(12'h000, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
        // Each skipped add sets its own bit in x3
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 6; k++) begin
                emit(enc_b(13'd8, p == 0 ? 5'd2 : 5'd1, 5'd1, branch_f3[k]));
                emit(enc_i(12'(1 << (k + 6 * p)), 5'd3, 3'd0, 5'd3, OPC_OP_IMM));
            end
        end
        emit(enc_j(21'd8, 5'd4));
        emit(enc_i(12'h7FF, 5'd3, 3'd0, 5'd3, OPC_OP_IMM));
        emit(enc_u(20'h00000, 5'd5, OPC_AUIPC));
        emit(enc_i(12'd12, 5'd5, 3'd0, 5'd6, OPC_JALR));
        emit(enc_i(12'h7FF, 5'd3, 3'd0, 5'd3, OPC_OP_IMM));
        for (int k = 3; k < 7; k++) emit(enc_s(12'h480 + 12'(4 * k), 5'(k), 5'd0, F3_WORD));
        sec_start[3] = load_pc;
        emit(enc_u(20'h89ABC, 5'd7, OPC_LUI));
        emit(enc_i(12'h5EF, 5'd7, 3'd0, 5'd7, OPC_OP_IMM));
        for (int k = 0; k < 4; k++) emit(enc_s(12'h500 + 12'(k), 5'd7, 5'd0, F3_BYTE));
        emit(enc_s(12'h504, 5'd7, 5'd0, F3_HALF));
        emit(enc_s(12'h506, 5'd7, 5'd0, F3_HALF));
        emit(enc_s(12'h508, 5'd7, 5'd0, F3_WORD));
        sec_start[4] = load_pc;
        // Every lane of 0x508 signed and unsigned, then one untouched word
        for (int k = 0; k < 14; k++) begin
            if (k < 8) begin
                f3 = (k < 4) ? F3_BYTE : F3_BYTE_U;
                off = 12'h508 + 12'(k % 4);
            end else if (k < 12) begin
                f3 = (k < 10) ? F3_HALF : F3_HALF_U;
                off = 12'h508 + 12'(2 * (k % 2));
            end else begin
                f3 = F3_WORD;
                off = (k == 12) ? 12'h508 : 12'h600;
            end
            emit(enc_i(off, 5'd0, f3, 5'd8, OPC_LOAD));
            emit(enc_s(12'h540 + 12'(4 * k), 5'd8, 5'd0, F3_WORD));
        end
        rand_start = load_pc;
    endtask

    function automatic int section_of(input word_t pc);
        for (int k = 4; k >= 1; k--) begin
            if (pc >= sec_start[k]) return k;
        end
        return 1;
    endfunction

    task automatic fail_value(input string what, input word_t exp, input word_t act);
        $display("Fail %s %s: expected %h, actual %h", test_names[phase], what, exp, act);
        test_errs[phase]++;
    endtask

    task automatic fail_text(input string msg);
        $display("Error in %s test: %s, pc %h", test_names[phase], msg, ref_pc);
        test_errs[phase]++;
    endtask

    task automatic finish_test(input int k);
        if (test_errs[k] == 0) $display("Test %s: ok", test_names[k]);
        else $display("Test %s: FAILED with %0d errors", test_names[k], test_errs[k]);
    endtask

    task automatic end_run();
        int failed;
        int errors;
        failed = 0;
        errors = 0;
        finish_test(phase);
        for (int k = 0; k < 6; k++) begin
            errors += test_errs[k];
            if (test_errs[k] != 0) failed++;
        end
        $display("Tests run: 6, tests failed: %0d, errors: %0d", failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic check_cycle();
        step_t exp;
        int    next_phase;
        if (!rst_n) begin
            if (o_dmem_req.write !== 1'b0) fail_text("write strobe raised during reset");
            if (o_dmem_req.read !== 1'b0) fail_text("read strobe raised during reset");
            return;
        end
        if (started) begin
            if (!in_random && ref_pc == rand_start) in_random = 1'b1;
            next_phase = in_random ? 5 : section_of(ref_pc);
            if (next_phase != phase) begin
                finish_test(phase);
                phase = next_phase;
            end
        end
        if (o_pc !== ref_pc) begin
            fail_value("pc", ref_pc, o_pc);
            ref_pc = o_pc;
        end
        exp = ref_step(fetch_instr(ref_pc));
        if (exp.is_store) begin
            if (o_dmem_req.write !== 1'b1) begin
                fail_text("store did not raise the write strobe");
            end else begin
                if (o_dmem_req.addr !== exp.addr) begin
                    fail_value("store address", exp.addr, o_dmem_req.addr);
                end
                if (o_dmem_req.byte_en !== exp.be) begin
                    fail_value("byte enable", {28'b0, exp.be}, {28'b0, o_dmem_req.byte_en});
                end
                if ((o_dmem_req.wdata & lane_mask(exp.be)) !== (exp.data & lane_mask(exp.be))) begin
                    fail_value("store data", exp.data, o_dmem_req.wdata);
                end
            end
        end else if (o_dmem_req.write !== 1'b0) begin
            fail_text("write strobe raised without a store");
        end
        if (o_dmem_req.read !== exp.is_load) begin
            fail_value("read strobe", {31'b0, exp.is_load}, {31'b0, o_dmem_req.read});
        end else if (exp.is_load && o_dmem_req.addr !== exp.addr) begin
            fail_value("load address", exp.addr, o_dmem_req.addr);
        end
        if (o_dmem_req.write === 1'b1) begin
            dmem[o_dmem_req.addr] = merge_lanes(read_dmem(o_dmem_req.addr), o_dmem_req.wdata,
                                                o_dmem_req.byte_en);
        end
        started = 1'b1;
        if (in_random) random_done++;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        i_instr = enc_s(12'h400, 5'd1, 5'd0, F3_WORD);
        i_dmem_rdata = '0;
        lcg_state = 32'd8;
        ref_pc = RESET_PC;
        for (int k = 0; k < 32; k++) ref_regs[k] = '0;
        in_random = 1'b0;
        started = 1'b0;
        phase = 0;
        random_done = 0;
        load_directed();
        // A store and a load take turns while reset holds the strobes low
        for (int k = 1; k < 10; k++) begin
            @(posedge clk);
            #1 i_instr = k[0] ? enc_i(12'h400, 5'd0, F3_WORD, 5'd1, OPC_LOAD)
                              : enc_s(12'h400, 5'd1, 5'd0, F3_WORD);
        end
        @(posedge clk);
        #1 rst_n = 1'b1;
        // Memories answer a short delay after each edge
        forever begin
            i_instr = fetch_instr(o_pc);
            #1 i_dmem_rdata = read_dmem(o_dmem_req.addr);
            @(posedge clk);
            #1;
        end
    end

    initial begin
        while (random_done < RANDOM_COUNT) begin
            @(negedge clk);
            check_cycle();
        end
        end_run();
    end

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired before the random stream completed");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: holy_core.f
+incdir+verification
design/holy_core_pkg.sv
design/pc_unit.sv
design/control.sv
design/regfile.sv
design/signext.sv
design/alu.sv
design/load_store_decoder.sv
design/load_write_back.sv
design/holy_core.sv
verification/holy_core_tb.sv

// File: Makefile
SIM := obj_dir/Vholy_core_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): holy_core.f $(wildcard design/*.sv) $(wildcard verification/*.sv verification/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module holy_core_tb \
		-f holy_core.f -o Vholy_core_tb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
